// File: logic/router_settings.svh
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// inputs competing for the output link.
`define ROUTER_PORTS 5

// flit field widths.
`define FLIT_ID_WIDTH 3
`define LENGTH_WIDTH 12
`define PAYLOAD_WIDTH 16

// flit id of the first flit of a packet.
`define HEAD_FLIT_ID 1

`endif

// File: logic/routerPkg.sv
`include "router_settings.svh"

package routerPkg;

  // head, body or tail marker.
  typedef logic [`FLIT_ID_WIDTH-1:0] flitId_t;

  // cycles an owner may hold the link.
  typedef logic [`LENGTH_WIDTH-1:0] pktLength_t;

  typedef logic [`PAYLOAD_WIDTH-1:0] payload_t;

  typedef struct packed {
    flitId_t    flitId;
    pktLength_t length;   // only meaningful on a head flit.
    payload_t   payload;
  } flit_t;

  // bit 0 local, then north, east, west, south.
  typedef logic [`ROUTER_PORTS-1:0] portReq_t;

  // Owner states are one bit above the matching input index,
  // so grant[i+1] is set while input i holds the link.
  typedef enum logic [`ROUTER_PORTS:0] {
    grantIdle  = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast  = 6'b001000,
    grantWest  = 6'b010000,
    grantSouth = 6'b100000
  } grantState_t;

endpackage

// File: logic/grantTimer.sv
module grantTimer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  routerPkg::pktLength_t length,
  input  logic                 run,
  output logic                 expired
);

  routerPkg::pktLength_t limit;
  routerPkg::pktLength_t count;

  // limit follows the latest requested head flit.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (load)
    begin
      limit <= length;
    end
  end

  // count restarts each time the owner stops running.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  // owner gets limit+1 granted cycles.
  assign expired = (count == limit);

endmodule

// File: logic/outputArbiter.sv
`include "router_settings.svh"

module outputArbiter (
  input  logic                                    clk,
  input  logic                                    rst,
  input  routerPkg::portReq_t                     inReq,
  input  routerPkg::flit_t [`ROUTER_PORTS-1:0]    inFlit,
  output routerPkg::grantState_t                  grant
);

  routerPkg::grantState_t              nextGrant;
  logic [$clog2(`ROUTER_PORTS)-1:0]    ownerIdx;
  logic [`ROUTER_PORTS-1:0]            ownerVec;
  logic                                ownerHolds;
  logic [`ROUTER_PORTS-1:0]            timerLoad;
  logic [`ROUTER_PORTS-1:0]            timerRun;
  logic [`ROUTER_PORTS-1:0]            timerExpired;

  // Walks the ring from start for span inputs and returns the
  // owner state of the first one requesting, or idle if none.
  function automatic routerPkg::grantState_t firstRequester(
    input routerPkg::portReq_t req,
    input int unsigned         start,
    input int unsigned         span
  );
    routerPkg::grantState_t winner;
    logic                   found;
    int unsigned            idx;
    winner = routerPkg::grantIdle;
    found  = 1'b0;
    for (int unsigned i = 0; i < span; i++)
    begin
      idx = (start + i) % `ROUTER_PORTS;
      if (!found && req[idx])
      begin
        winner = routerPkg::grantState_t'(routerPkg::grantLocal << idx);
        found  = 1'b1;
      end
    end
    return winner;
  endfunction

  // one-hot owner bits line up with the input order.
  assign ownerVec = grant[`ROUTER_PORTS:1];

  // timers count only while their owner keeps asking.
  assign timerRun = ownerVec & inReq;

  always_comb
  begin
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      timerLoad[i] = inReq[i] &&
        (inFlit[i].flitId == routerPkg::flitId_t'(`HEAD_FLIT_ID));
    end
  end

  grantTimer localTimer (
    .clk     (clk),
    .rst     (rst),
    .load    (timerLoad[0]),
    .length  (inFlit[0].length),
    .run     (timerRun[0]),
    .expired (timerExpired[0])
  );

  grantTimer northTimer (
    .clk     (clk),
    .rst     (rst),
    .load    (timerLoad[1]),
    .length  (inFlit[1].length),
    .run     (timerRun[1]),
    .expired (timerExpired[1])
  );

  grantTimer eastTimer (
    .clk     (clk),
    .rst     (rst),
    .load    (timerLoad[2]),
    .length  (inFlit[2].length),
    .run     (timerRun[2]),
    .expired (timerExpired[2])
  );

  grantTimer westTimer (
    .clk     (clk),
    .rst     (rst),
    .load    (timerLoad[3]),
    .length  (inFlit[3].length),
    .run     (timerRun[3]),
    .expired (timerExpired[3])
  );

  grantTimer southTimer (
    .clk     (clk),
    .rst     (rst),
    .load    (timerLoad[4]),
    .length  (inFlit[4].length),
    .run     (timerRun[4]),
    .expired (timerExpired[4])
  );

  always_comb
  begin
    ownerIdx = '0;
    case (grant)
      routerPkg::grantNorth: ownerIdx = 3'd1;
      routerPkg::grantEast:  ownerIdx = 3'd2;
      routerPkg::grantWest:  ownerIdx = 3'd3;
      routerPkg::grantSouth: ownerIdx = 3'd4;
      default:               ownerIdx = 3'd0;
    endcase
  end

  assign ownerHolds = inReq[ownerIdx] && !timerExpired[ownerIdx];

  always_comb
  begin
    nextGrant = routerPkg::grantIdle;
    case (grant)
      routerPkg::grantIdle:
      begin
        nextGrant = firstRequester(inReq, 0, `ROUTER_PORTS); // fixed priority.
      end
      routerPkg::grantLocal,
      routerPkg::grantNorth,
      routerPkg::grantEast,
      routerPkg::grantWest,
      routerPkg::grantSouth:
      begin
        if (ownerHolds)
        begin
          nextGrant = grant;
        end
        else
        begin
          // rivals only, starting after the owner.
          nextGrant = firstRequester(inReq, int'(ownerIdx) + 1, `ROUTER_PORTS - 1);
        end
      end
      default:
      begin
        nextGrant = routerPkg::grantIdle; // recover from a bad encoding.
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= routerPkg::grantIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

endmodule

// File: logic/flitSwitch.sv
`include "router_settings.svh"

module flitSwitch (
  input  logic                                    clk,
  input  logic                                    rst,
  input  routerPkg::grantState_t                  grant,
  input  routerPkg::portReq_t                     inReq,
  input  routerPkg::flit_t [`ROUTER_PORTS-1:0]    inFlit,
  output routerPkg::flit_t                        outFlit,
  output logic                                    outValid
);

  routerPkg::flit_t selFlit;
  logic             selReq;

  // one-hot grant steers the mux.
  always_comb
  begin
    selFlit = '0;
    selReq  = 1'b0;
    case (grant)
      routerPkg::grantLocal:
      begin
        selFlit = inFlit[0];
        selReq  = inReq[0];
      end
      routerPkg::grantNorth:
      begin
        selFlit = inFlit[1];
        selReq  = inReq[1];
      end
      routerPkg::grantEast:
      begin
        selFlit = inFlit[2];
        selReq  = inReq[2];
      end
      routerPkg::grantWest:
      begin
        selFlit = inFlit[3];
        selReq  = inReq[3];
      end
      routerPkg::grantSouth:
      begin
        selFlit = inFlit[4];
        selReq  = inReq[4];
      end
      default:
      begin
        selReq = 1'b0; // idle consumes nothing.
      end
    endcase
  end

  // A flit is consumed only when its input is both granted and
  // still requesting. The link then carries it one cycle later.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outFlit  <= '0;
    end
    else
    begin
      outValid <= selReq;
      if (selReq)
      begin
        outFlit <= selFlit; // otherwise hold the last flit.
      end
    end
  end

endmodule

// File: logic/outputPortAllocator.sv
`include "router_settings.svh"

module outputPortAllocator (
  input  logic                                    clk,
  input  logic                                    rst,
  input  routerPkg::portReq_t                     inReq,
  input  routerPkg::flit_t [`ROUTER_PORTS-1:0]    inFlit,
  output routerPkg::grantState_t                  grant,
  output routerPkg::flit_t                        outFlit,
  output logic                                    outValid
);

  // registered arbiter state, shared with the switch.
  routerPkg::grantState_t linkOwner;

  outputArbiter arbiter0 (
    .clk   (clk),
    .rst   (rst),
    .inReq (inReq),
    .inFlit(inFlit),
    .grant (linkOwner)
  );

  flitSwitch switch0 (
    .clk     (clk),
    .rst     (rst),
    .grant   (linkOwner),
    .inReq   (inReq),
    .inFlit  (inFlit),
    .outFlit (outFlit),
    .outValid(outValid)
  );

  assign grant = linkOwner;

endmodule

// File: testbench/allocatorTb.sv
`include "router_settings.svh"

module allocatorTb;

  localparam int WaitLimit = 200;
  localparam int PacketsPerSource = 15;
  localparam int unsigned Seed = 32'h5890_2487;

  logic                                  clk;
  logic                                  rst;
  routerPkg::portReq_t                   inReq;
  routerPkg::flit_t [`ROUTER_PORTS-1:0]  inFlit;
  routerPkg::grantState_t                grant;
  routerPkg::flit_t                      outFlit;
  logic                                  outValid;

  // reference model state.
  routerPkg::grantState_t    expGrant = routerPkg::grantIdle;
  routerPkg::flit_t          expFlit = '0;
  logic                      expValid = 1'b0;
  routerPkg::pktLength_t     limitModel [`ROUTER_PORTS];
  routerPkg::pktLength_t     countModel [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0]  consumed = '0; // flit taken at the last rising edge.

  outputPortAllocator dut0 (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq),
    .inFlit  (inFlit),
    .grant   (grant),
    .outFlit (outFlit),
    .outValid(outValid)
  );

  always #2 clk = ~clk;

  task automatic reportMismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    $display("test failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic abortRun(input string why);
    $display("%0t %s", $time, why);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  function automatic int ownerOf(input routerPkg::grantState_t g);
    int idx;
    case (g)
      routerPkg::grantLocal: idx = 0;
      routerPkg::grantNorth: idx = 1;
      routerPkg::grantEast:  idx = 2;
      routerPkg::grantWest:  idx = 3;
      routerPkg::grantSouth: idx = 4;
      default:               idx = -1;
    endcase
    return idx;
  endfunction

  function automatic routerPkg::grantState_t stateFor(input int idx);
    routerPkg::grantState_t st;
    case (idx)
      0:       st = routerPkg::grantLocal;
      1:       st = routerPkg::grantNorth;
      2:       st = routerPkg::grantEast;
      3:       st = routerPkg::grantWest;
      4:       st = routerPkg::grantSouth;
      default: st = routerPkg::grantIdle;
    endcase
    return st;
  endfunction

  // Scans run backwards so the earliest candidate in the order wins.
  function automatic routerPkg::grantState_t predictNext(
    input routerPkg::grantState_t g,
    input routerPkg::portReq_t    req,
    input logic [4:0]             timedOut
  );
    routerPkg::grantState_t nxt;
    int                     owner;
    int                     cand;
    nxt = routerPkg::grantIdle;
    owner = ownerOf(g);
    if (owner < 0)
    begin
      for (int i = 4; i >= 0; i--)
      begin
        if (req[i])
        begin
          nxt = stateFor(i);
        end
      end
    end
    else if (req[owner] && !timedOut[owner])
    begin
      nxt = g; // owner keeps the link.
    end
    else
    begin
      for (int k = 4; k >= 1; k--)
      begin
        cand = (owner + k) % 5;
        if (req[cand])
        begin
          nxt = stateFor(cand);
        end
      end
    end
    return nxt;
  endfunction

  // pre-edge values of DUT registers are sampled here.
  always @(posedge clk)
  begin : refModel
    int                     owner;
    logic [4:0]             timedOut;
    routerPkg::grantState_t nextGrant;
    if (rst)
    begin
      expGrant = routerPkg::grantIdle;
      expValid = 1'b0;
      expFlit  = '0;
      consumed = '0;
      for (int i = 0; i < `ROUTER_PORTS; i++)
      begin
        limitModel[i] = '0;
        countModel[i] = '0;
      end
    end
    else
    begin
      assert (grant === expGrant) else reportMismatch("grant", grant, expGrant);
      assert (outValid === expValid) else reportMismatch("outValid", outValid, expValid);
      assert (outFlit === expFlit) else reportMismatch("outFlit", outFlit, expFlit);
      for (int i = 0; i < `ROUTER_PORTS; i++)
      begin
        timedOut[i] = (countModel[i] == limitModel[i]);
      end
      nextGrant = predictNext(expGrant, inReq, timedOut);
      owner = ownerOf(expGrant);
      consumed = '0;
      expValid = 1'b0;
      if (owner >= 0 && inReq[owner])
      begin
        consumed[owner] = 1'b1;
        expValid = 1'b1;
        expFlit  = inFlit[owner];
      end
      for (int i = 0; i < `ROUTER_PORTS; i++)
      begin
        if (inReq[i] && inFlit[i].flitId == routerPkg::flitId_t'(`HEAD_FLIT_ID))
        begin
          limitModel[i] = inFlit[i].length;
        end
        if (i == owner && inReq[i])
        begin
          countModel[i] = countModel[i] + 1;
        end
        else
        begin
          countModel[i] = '0;
        end
      end
      expGrant = nextGrant;
    end
  end

  // one packet source per input driving on the falling edge.
  task automatic runSource(input int idx);
    routerPkg::flit_t f;
    int               gap;
    int               flits;
    int               seq;
    int               waitCycles;
    seq = 0;
    for (int p = 0; p < PacketsPerSource; p++)
    begin
      gap = (p == 0) ? 0 : int'($urandom % 6);
      if (gap > 0)
      begin
        inReq[idx] = 1'b0;
        for (int c = 0; c < gap; c++)
        begin
          @(negedge clk);
        end
      end
      flits = 1 + int'($urandom % 8);
      for (int k = 0; k < flits; k++)
      begin
        if (k == 0)
        begin
          f.flitId = routerPkg::flitId_t'(`HEAD_FLIT_ID);
          f.length = routerPkg::pktLength_t'($urandom % 7);
        end
        else
        begin
          f.flitId = (k == flits - 1) ? routerPkg::flitId_t'(3) : routerPkg::flitId_t'(2);
          f.length = '0;
        end
        f.payload = {3'(idx), 13'(seq)};
        inFlit[idx] = f;
        inReq[idx]  = 1'b1;
        waitCycles = 0;
        do
        begin
          @(negedge clk);
          waitCycles++;
          if (waitCycles > WaitLimit)
          begin
            abortRun($sformatf("input %0d was never granted", idx));
          end
        end
        while (!consumed[idx]);
        seq++;
      end
    end
    inReq[idx] = 1'b0;
  endtask

  initial
  begin : mainFlow
    logic drained;
    void'($urandom(Seed));
    clk    = 1'b0;
    rst    = 1'b1;
    inReq  = '0;
    inFlit = '0;
    for (int c = 0; c < 5; c++)
    begin
      @(negedge clk);
    end
    rst = 1'b0;
    // nothing requests yet so the link stays idle.
    for (int c = 0; c < 6; c++)
    begin
      @(negedge clk);
      assert (grant === routerPkg::grantIdle)
        else reportMismatch("grant", grant, routerPkg::grantIdle);
      assert (outValid === 1'b0) else reportMismatch("outValid", outValid, 1'b0);
    end
    fork
      runSource(0);
      runSource(1);
      runSource(2);
      runSource(3);
      runSource(4);
    join
    drained = 1'b0;
    for (int c = 0; c < WaitLimit && !drained; c++)
    begin
      @(negedge clk);
      drained = (grant == routerPkg::grantIdle) && !outValid;
    end
    if (!drained)
    begin
      abortRun("link did not return to idle after the last packet");
    end
    else
    begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// File: all.f
+incdir+logic
logic/routerPkg.sv
logic/grantTimer.sv
logic/outputArbiter.sv
logic/flitSwitch.sv
logic/outputPortAllocator.sv
testbench/allocatorTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the allocator testbench with Verilator and runs it.
# Pass or fail is taken from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBinary=allocatorSim
logFile=sim.log

rm -rf "$buildDir" "$logFile"

verilator --binary --assert -Wno-fatal \
  --top-module allocatorTb \
  --Mdir "$buildDir" \
  -o "$simBinary" \
  -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
fi

grep -qx "test passed" "$logFile"
if [ $? -ne 0 ]; then
  echo "FAILED: pass message not found in $logFile"
  exit 1
fi

echo "PASSED"
exit 0
